// File: Bender.yml
package:
  name: pcs_tx

sources:
  - files:
      - logic/pcs_pkg.sv
      - logic/reg_slice.sv
      - logic/block_dispatch.sv
      - logic/block_encoder.sv
      - logic/block_scrambler.sv
      - logic/pcs_lane.sv
      - logic/block_collector.sv
      - logic/pcs_tx_top.sv
  - target: test
    files:
      - test/pcs_tx_asserts.sv
      - test/pcs_tx_tb.sv

// File: files.f
logic/pcs_pkg.sv
logic/reg_slice.sv
logic/block_dispatch.sv
logic/block_encoder.sv
logic/block_scrambler.sv
logic/pcs_lane.sv
logic/block_collector.sv
logic/pcs_tx_top.sv
test/pcs_tx_asserts.sv
test/pcs_tx_tb.sv

// File: logic/block_collector.sv
`timescale 1ns/100ps

module block_collector #(
  parameter int LANES = 4
) (
  input  logic                              ck,
  input  logic                              arst_n,
  input  logic [LANES-1:0]                  lane_out_valid,
  output logic [LANES-1:0]                  lane_out_ready,
  input  pcs_pkg::block_t [LANES-1:0]       lane_out_block,
  output logic                              blk_valid,
  input  logic                              blk_ready,
  output pcs_pkg::block_t                   blk
);

  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic [PTR_W-1:0] ptr;  // same sequence as the dispatcher

  // wait on the selected lane only, keeps input order
  assign blk_valid      = lane_out_valid[ptr];
  assign blk            = lane_out_block[ptr];
  assign lane_out_ready = LANES'(blk_ready) << ptr;

  always_ff @(posedge ck or negedge arst_n)
  begin
    if (!arst_n)
      ptr <= '0;
    else if (blk_valid && blk_ready)
    begin
      if (ptr == PTR_W'(LANES - 1))
        ptr <= '0;
      else
        ptr <= ptr + 1'b1;
    end
  end

endmodule

// File: logic/block_dispatch.sv
`timescale 1ns/100ps

module block_dispatch #(
  parameter int LANES = 4
) (
  input  logic                 ck,
  input  logic                 arst_n,
  input  logic                 word_valid,
  output logic                 word_ready,
  input  pcs_pkg::xgmii_word_t word,
  output logic [LANES-1:0]     lane_in_valid,
  input  logic [LANES-1:0]     lane_in_ready,
  output logic [63:0]          lane_in_data,
  output logic [7:0]           lane_in_ctrl
);

  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic [PTR_W-1:0] ptr;  // lane that takes the next word

  // payload fans out, only one valid is ever high
  assign lane_in_data  = word.data;
  assign lane_in_ctrl  = word.ctrl;
  assign lane_in_valid = LANES'(word_valid) << ptr;
  assign word_ready    = lane_in_ready[ptr];

  always_ff @(posedge ck or negedge arst_n)
  begin
    if (!arst_n)
      ptr <= '0;
    else if (word_valid && word_ready)
    begin
      if (ptr == PTR_W'(LANES - 1))
        ptr <= '0;
      else
        ptr <= ptr + 1'b1;
    end
  end

endmodule

// File: logic/block_encoder.sv
`timescale 1ns/100ps

module block_encoder (
  input  logic            ck,
  input  logic            arst_n,
  input  logic            in_valid,
  output logic            in_ready,
  input  logic [63:0]     in_data,
  input  logic [7:0]      in_ctrl,
  output logic            out_valid,
  input  logic            out_ready,
  output pcs_pkg::block_t out_block
);

  // indexed by terminate position
  localparam logic [7:0][7:0] term_types = {
    pcs_pkg::btype_term7, pcs_pkg::btype_term6,
    pcs_pkg::btype_term5, pcs_pkg::btype_term4,
    pcs_pkg::btype_term3, pcs_pkg::btype_term2,
    pcs_pkg::btype_term1, pcs_pkg::btype_term0
  };

  pcs_pkg::block_t enc_block;
  logic            idle_hit;
  logic            start_hit;
  logic            term_hit;
  logic [63:0]     term_payload;

  assign in_ready = !out_valid || out_ready;

  assign idle_hit = (in_ctrl == 8'hff) && (in_data[7:0] == pcs_pkg::char_idle)
                    && (in_data[63:56] == pcs_pkg::char_idle);
  assign start_hit = (in_ctrl == 8'h01) && (in_data[7:0] == pcs_pkg::char_start);

  // terminate at byte k: upper 8-k bytes are control, byte k is the terminate char
  always_comb
  begin
    term_hit     = 1'b0;
    term_payload = '0;
    for (int k = 0; k < 8; k++)
    begin
      if (in_ctrl == (8'hff << k) && in_data[8*k +: 8] == pcs_pkg::char_term)
      begin
        term_hit     = 1'b1;
        // k data bytes shifted above the type byte, rest zero
        term_payload = ({in_data[55:0], 8'h00} & (((64'd1 << (8*k)) - 64'd1) << 8))
                       | {56'd0, term_types[k]};
      end
    end
  end

  always_comb
  begin
    enc_block.sync    = pcs_pkg::sync_ctrl;
    enc_block.payload = {8{pcs_pkg::char_error}};  // error block by default
    if (in_ctrl == 8'h00)
    begin
      enc_block.sync    = pcs_pkg::sync_data;
      enc_block.payload = in_data;
    end
    else if (idle_hit)
      enc_block.payload = {56'd0, pcs_pkg::btype_idle};
    else if (start_hit)
      enc_block.payload = {in_data[63:8], pcs_pkg::btype_start};
    else if (term_hit)
      enc_block.payload = term_payload;
  end

  always_ff @(posedge ck or negedge arst_n)
  begin
    if (!arst_n)
      out_valid <= 1'b0;
    else if (in_ready)
      out_valid <= in_valid;
  end

  always_ff @(posedge ck)
  begin
    if (in_valid && in_ready)
      out_block <= enc_block;
  end

endmodule

// File: logic/block_scrambler.sv
`timescale 1ns/100ps

module block_scrambler (
  input  logic            ck,
  input  logic            arst_n,
  input  logic            in_valid,
  output logic            in_ready,
  input  pcs_pkg::block_t in_block,
  output logic            out_valid,
  input  logic            out_ready,
  output pcs_pkg::block_t out_block
);

  logic [57:0] state;       // last 58 scrambled bits, newest in bit 0
  logic [57:0] next_state;
  logic [63:0] scr;
  logic        accept;

  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  always_comb
  begin
    next_state = state;
    for (int i = 0; i < 64; i++)
    begin
      scr[i]     = in_block.payload[i] ^ next_state[38] ^ next_state[57];
      next_state = {next_state[56:0], scr[i]};  // output bit feeds back
    end
  end

  always_ff @(posedge ck or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_valid <= 1'b0;
      state     <= pcs_pkg::scram_seed;
    end
    else
    begin
      if (in_ready)
        out_valid <= in_valid;
      if (accept)
        state <= next_state;
    end
  end

  always_ff @(posedge ck)
  begin
    if (accept)
      out_block <= {scr, in_block.sync};  // header unscrambled
  end

endmodule

// File: logic/pcs_lane.sv
`timescale 1ns/100ps

module pcs_lane (
  input  logic            ck,
  input  logic            arst_n,
  input  logic            in_valid,
  output logic            in_ready,
  input  logic [63:0]     in_data,
  input  logic [7:0]      in_ctrl,
  output logic            out_valid,
  input  logic            out_ready,
  output pcs_pkg::block_t out_block
);

  // between encoder and scrambler
  logic            enc_valid;
  logic            enc_ready;
  pcs_pkg::block_t enc_block;

  block_encoder u_encoder (
    .ck        (ck),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .in_ctrl   (in_ctrl),
    .out_valid (enc_valid),
    .out_ready (enc_ready),
    .out_block (enc_block)
  );

  // own scrambler state per lane
  block_scrambler u_scrambler (
    .ck        (ck),
    .arst_n    (arst_n),
    .in_valid  (enc_valid),
    .in_ready  (enc_ready),
    .in_block  (enc_block),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_block (out_block)
  );

endmodule

// File: logic/pcs_pkg.sv
package pcs_pkg;

  // input word as it arrives, data above its per-byte control flags
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  ctrl;
  } xgmii_word_t;

  // 66-bit block, sync header in the low bits
  typedef struct packed {
    logic [63:0] payload;
    logic [1:0]  sync;
  } block_t;

  parameter logic [1:0] sync_data = 2'b10;
  parameter logic [1:0] sync_ctrl = 2'b01;

  // control characters
  parameter logic [7:0] char_idle  = 8'h07;
  parameter logic [7:0] char_start = 8'hfb;
  parameter logic [7:0] char_term  = 8'hfd;
  parameter logic [7:0] char_error = 8'h1e;

  // block type field, first payload byte of a control block
  parameter logic [7:0] btype_idle  = 8'h1e;
  parameter logic [7:0] btype_start = 8'h78;
  parameter logic [7:0] btype_term0 = 8'h87;  // terminate in byte 0
  parameter logic [7:0] btype_term1 = 8'h99;
  parameter logic [7:0] btype_term2 = 8'haa;
  parameter logic [7:0] btype_term3 = 8'hb4;
  parameter logic [7:0] btype_term4 = 8'hcc;
  parameter logic [7:0] btype_term5 = 8'hd2;
  parameter logic [7:0] btype_term6 = 8'he1;
  parameter logic [7:0] btype_term7 = 8'hff;  // terminate in byte 7

  // scrambler state after reset
  parameter logic [57:0] scram_seed = '1;

endpackage

// File: logic/pcs_tx_top.sv
`timescale 1ns/100ps

module pcs_tx_top #(
  parameter int LANES = 4
) (
  input  logic        ck,
  input  logic        arst_n,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic [63:0] in_data,
  input  logic [7:0]  in_ctrl,
  output logic        out_valid,
  input  logic        out_ready,
  output logic [65:0] out_block
);

  logic                         word_valid;
  logic                         word_ready;
  pcs_pkg::xgmii_word_t         word;
  logic [LANES-1:0]             lane_in_valid;
  logic [LANES-1:0]             lane_in_ready;
  logic [63:0]                  lane_in_data;
  logic [7:0]                   lane_in_ctrl;
  logic [LANES-1:0]             lane_out_valid;
  logic [LANES-1:0]             lane_out_ready;
  pcs_pkg::block_t [LANES-1:0]  lane_out_block;
  logic                         blk_valid;
  logic                         blk_ready;
  pcs_pkg::block_t              blk;

  reg_slice #(.payload_t(pcs_pkg::xgmii_word_t)) u_in_slice (
    .ck (ck), .arst_n (arst_n),
    .in_valid (in_valid), .in_ready (in_ready), .in_payload ({in_data, in_ctrl}),
    .out_valid (word_valid), .out_ready (word_ready), .out_payload (word)
  );

  block_dispatch #(.LANES(LANES)) u_dispatch (
    .ck (ck), .arst_n (arst_n),
    .word_valid (word_valid), .word_ready (word_ready), .word (word),
    .lane_in_valid (lane_in_valid), .lane_in_ready (lane_in_ready),
    .lane_in_data (lane_in_data), .lane_in_ctrl (lane_in_ctrl)
  );

  for (genvar i = 0; i < LANES; i++)
  begin : g_lane
    pcs_lane u_lane (
      .ck (ck), .arst_n (arst_n),
      .in_valid (lane_in_valid[i]), .in_ready (lane_in_ready[i]),
      .in_data (lane_in_data), .in_ctrl (lane_in_ctrl),
      .out_valid (lane_out_valid[i]), .out_ready (lane_out_ready[i]),
      .out_block (lane_out_block[i])
    );
  end

  block_collector #(.LANES(LANES)) u_collector (
    .ck (ck), .arst_n (arst_n),
    .lane_out_valid (lane_out_valid), .lane_out_ready (lane_out_ready),
    .lane_out_block (lane_out_block),
    .blk_valid (blk_valid), .blk_ready (blk_ready), .blk (blk)
  );

  reg_slice #(.payload_t(pcs_pkg::block_t)) u_out_slice (
    .ck (ck), .arst_n (arst_n),
    .in_valid (blk_valid), .in_ready (blk_ready), .in_payload (blk),
    .out_valid (out_valid), .out_ready (out_ready), .out_payload (out_block)
  );

endmodule

// File: logic/reg_slice.sv
`timescale 1ns/100ps

module reg_slice #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     ck,
  input  logic     arst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_payload,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_payload
);

  logic     main_valid;
  logic     skid_valid;
  payload_t main_q;
  payload_t skid_q;
  logic     main_load;  // main register free this cycle

  assign main_load   = out_ready || !main_valid;
  assign in_ready    = !skid_valid;  // purely registered
  assign out_valid   = main_valid;
  assign out_payload = main_q;

  always_ff @(posedge ck or negedge arst_n)
  begin
    if (!arst_n)
    begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end
    else if (main_load)
    begin
      main_valid <= skid_valid || in_valid;  // skid word goes first
      skid_valid <= 1'b0;
    end
    else if (in_valid && in_ready)
      skid_valid <= 1'b1;  // output stalled, park the word
  end

  always_ff @(posedge ck)
  begin
    if (main_load)
      main_q <= skid_valid ? skid_q : in_payload;
    if (!main_load && in_valid && in_ready)
      skid_q <= in_payload;
  end

endmodule

// File: test/pcs_tx_asserts.sv
`timescale 1ns/100ps

module pcs_tx_asserts (
  input logic        ck,
  input logic        arst_n,
  input logic        in_ready,
  input logic        out_valid,
  input logic        out_ready,
  input logic [65:0] out_block
);

  int   fails = 0;
  logic stall_seen;  // out_ready has been low since reset

  always_ff @(posedge ck or negedge arst_n)
  begin
    if (!arst_n)
      stall_seen <= 1'b0;
    else if (!out_ready)
      stall_seen <= 1'b1;
  end

  reset_quiet: assert property (@(posedge ck) (!arst_n || $rose(arst_n)) |-> !out_valid)
  else
  begin
    $error("out_valid high during or right after reset");
    fails++;
  end

  // sender holds block until taken
  hold_block: assert property (@(posedge ck) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_block)))
  else
  begin
    $error("out_valid dropped or out_block changed before out_ready");
    fails++;
  end

  sync_ok: assert property (@(posedge ck) disable iff (!arst_n)
    out_valid |-> (out_block[1:0] == pcs_pkg::sync_data || out_block[1:0] == pcs_pkg::sync_ctrl))
  else
  begin
    $error("out_block carries an invalid sync header");
    fails++;
  end

  stall_first: assert property (@(posedge ck) disable iff (!arst_n) !in_ready |-> stall_seen)
  else
  begin
    $error("in_ready fell although out_ready was never low");
    fails++;
  end

endmodule

// File: test/pcs_tx_tb.sv
`timescale 1ns/100ps

module pcs_tx_tb;

  localparam int LANES   = 4;
  localparam int N_WORDS = 284;  // 40 + 3 + 8 + 3 + 200 + 30
  localparam int LIMIT   = 20 * N_WORDS + 100;

  logic        ck;
  logic        arst_n;
  logic        in_valid;
  logic        in_ready;
  logic [63:0] in_data;
  logic [7:0]  in_ctrl;
  logic        out_valid;
  logic        out_ready;
  logic [65:0] out_block;

  integer      seed = 32'he7dc;
  int          errors;
  int          cycles;
  int          out_cnt;
  int          ready_mode;  // 0 always ready, 1 random, 2 held low
  logic [71:0] stim_q[$];
  logic [71:0] exp_q[$];    // words already presented in order
  logic [57:0] hist[LANES];

  pcs_tx_top #(.LANES(LANES)) u_pcs_tx_top (.*);

  bind pcs_tx_top pcs_tx_asserts u_asserts (.*);

  initial ck = 1'b0;
  always #50 ck = ~ck;

  // kind 0 data, 1 idle, 2 start, 3..10 terminate at kind-3, 11 unknown mask
  function automatic logic [71:0] make_word(int kind);
    logic [63:0] d;
    int          k;
    d = {$random(seed), $random(seed)};
    case (kind)
      0: return {d, 8'h00};
      1: return {{8{pcs_pkg::char_idle}}, 8'hff};
      2: return {d[63:8], pcs_pkg::char_start, 8'h01};
      11: return {d, 8'h5a};
      default:
      begin
        k = kind - 3;
        for (int j = 0; j < 8; j++)
          if (j > k)
            d[8*j +: 8] = pcs_pkg::char_idle;
        d[8*k +: 8] = pcs_pkg::char_term;
        return {d, 8'hff << k};
      end
    endcase
  endfunction

  // expected unscrambled block from the encoding rules
  function automatic logic [65:0] encode_ref(logic [71:0] w);
    logic [63:0] d;
    logic [7:0]  c;
    logic [7:0]  m;
    logic [63:0] p;
    logic [7:0]  tt[8];
    d  = w[71:8];
    c  = w[7:0];
    tt = '{pcs_pkg::btype_term0, pcs_pkg::btype_term1, pcs_pkg::btype_term2,
           pcs_pkg::btype_term3, pcs_pkg::btype_term4, pcs_pkg::btype_term5,
           pcs_pkg::btype_term6, pcs_pkg::btype_term7};
    if (c == 8'h00)
      return {d, pcs_pkg::sync_data};
    if (c == 8'hff && d[7:0] == pcs_pkg::char_idle && d[63:56] == pcs_pkg::char_idle)
      return {56'd0, pcs_pkg::btype_idle, pcs_pkg::sync_ctrl};
    if (c == 8'h01 && d[7:0] == pcs_pkg::char_start)
      return {d[63:8], pcs_pkg::btype_start, pcs_pkg::sync_ctrl};
    for (int k = 0; k < 8; k++)
    begin
      p = {56'd0, tt[k]};
      for (int j = 0; j < 8; j++)
      begin
        m[j] = (j >= k);  // bytes k and up are control
        if (j < k)
          p[8*j+8 +: 8] = d[8*j +: 8];
      end
      if (c == m && d[8*k +: 8] == pcs_pkg::char_term)
        return {p, pcs_pkg::sync_ctrl};
    end
    return {{8{pcs_pkg::char_error}}, pcs_pkg::sync_ctrl};
  endfunction

  task automatic drain();
    while (stim_q.size() > 0 || exp_q.size() > 0)
      @(posedge ck);
  endtask

  always @(posedge ck)
  begin
    if (arst_n)
    begin
      if (!in_valid || in_ready)
      begin
        if (stim_q.size() > 0)
        begin
          {in_data, in_ctrl} <= stim_q[0];
          exp_q.push_back(stim_q.pop_front());
          in_valid <= 1'b1;
        end
        else
          in_valid <= 1'b0;
      end
      case (ready_mode)
        0: out_ready <= 1'b1;
        1: out_ready <= 1'($random(seed));
        default: out_ready <= 1'b0;
      endcase
    end
  end

  // descramble with the lane's own history before comparing
  always @(posedge ck)
  begin
    logic [57:0] h;
    logic [63:0] d;
    logic [65:0] exp_blk;
    if (out_valid && out_ready)
    begin
      h = hist[out_cnt % LANES];
      for (int i = 0; i < 64; i++)
      begin
        d[i] = out_block[i+2] ^ h[38] ^ h[57];
        h    = {h[56:0], out_block[i+2]};
      end
      hist[out_cnt % LANES] = h;
      out_cnt++;
      assert (exp_q.size() > 0)
      else
      begin
        $display("output block %0d arrived with no input word left for it", out_cnt);
        errors++;
      end
      if (exp_q.size() > 0)
      begin
        exp_blk = encode_ref(exp_q.pop_front());
        assert ({d, out_block[1:0]} == exp_blk)
        else
        begin
          $display("mismatch out_block expected %h received %h", exp_blk, {d, out_block[1:0]});
          errors++;
        end
      end
    end
  end

  always @(posedge ck)
  begin
    cycles++;
    if (cycles >= LIMIT)
    begin
      $display("timeout after %0d cycles, %0d words not yet out", cycles,
               stim_q.size() + exp_q.size());
      $display("errors: %0d", errors);
      $display("** FAIL **");
      $finish;
    end
  end

  initial
  begin
    logic [71:0] w;
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    in_ctrl    = '0;
    out_ready  = 1'b1;
    ready_mode = 0;
    errors     = 0;
    cycles     = 0;
    out_cnt    = 0;
    for (int i = 0; i < LANES; i++)
      hist[i] = pcs_pkg::scram_seed;
    repeat (2) @(posedge ck);
    arst_n <= 1'b1;

    repeat (40) stim_q.push_back(make_word(0));
    drain();
    stim_q.push_back(make_word(1));
    stim_q.push_back(make_word(1));
    stim_q.push_back(make_word(2));
    for (int k = 0; k < 8; k++)
      stim_q.push_back(make_word(3 + k));
    drain();

    stim_q.push_back(make_word(11));
    w = make_word(7);
    w[8*4+8 +: 8] = pcs_pkg::char_idle;  // terminate mask without the terminate char
    stim_q.push_back(w);
    w = make_word(2);
    w[15:8] = pcs_pkg::char_idle;  // start mask without the start char
    stim_q.push_back(w);
    drain();

    ready_mode = 1;
    repeat (200) stim_q.push_back(make_word($unsigned($random(seed)) % 12));
    drain();

    // full stall and release
    ready_mode = 2;
    repeat (30) stim_q.push_back(make_word(0));
    @(posedge ck);
    while (in_ready)
      @(posedge ck);
    assert (exp_q.size() - int'(in_valid) >= LANES * 2 + 2)
    else
    begin
      $display("in_ready fell after only %0d words with the output stalled",
               exp_q.size() - int'(in_valid));
      errors++;
    end
    ready_mode = 0;
    drain();

    $display("errors: %0d  assertion failures: %0d  blocks out: %0d", errors,
             u_pcs_tx_top.u_asserts.fails, out_cnt);
    if (errors == 0 && u_pcs_tx_top.u_asserts.fails == 0 && out_cnt == N_WORDS)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
